/* design/coreParams.svh */
// Core parameters for data width, memory depths and register count
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and address width
`define XLEN 32

// Memory depths in words
`define DMEM_WORDS 256
`define PMEM_WORDS 256

`define REG_COUNT 32

`endif

/* design/corePkg.sv */
// Core package with word, index and control select types
`default_nettype none

`include "coreParams.svh"

package corePkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;
    typedef logic [$clog2(`PMEM_WORDS)-1:0] pmemIdx_t;
    typedef logic [$clog2(`DMEM_WORDS)-1:0] dmemIdx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_EQ,
        ALU_NE,
        ALU_LT
    } aluOp_t;

    typedef enum logic [0:0] {A_RS1, A_ZERO} aSel_t;
    typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_U, B_IMM_S} bSel_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSel_t;

    typedef enum logic [0:0] {MEM_IDLE, MEM_WAIT} memState_t; // Load stall FSM

endpackage

`default_nettype wire

/* design/memBus.sv */
// Data bus between the core and the data memory
`timescale 1ns/1ps
`default_nettype none

interface memBus;
    import corePkg::*;

    logic  req;
    logic  we;
    word_t addr; // Byte address
    word_t wdata;
    word_t rdata;
    logic  stall; // High in the first cycle of a load

    modport core (output req, we, addr, wdata, input rdata, stall);
    modport mem (input req, we, addr, wdata, output rdata, stall);

endinterface

`default_nettype wire

/* design/instrDecoder.sv */
// Instruction decoder for the RV32I subset with illegal encoding detection
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  corePkg::word_t  instr_i,
    output corePkg::aluOp_t aluOp_o,
    output corePkg::aSel_t  aSel_o,
    output corePkg::bSel_t  bSel_o,
    output corePkg::wbSel_t wbSel_o,
    output logic            regWe_o,
    output logic            memReq_o,
    output logic            memWe_o,
    output logic            branch_o,
    output logic            jal_o,
    output logic            illegal_o
);
    import corePkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        aluOp_o   = ALU_ADD;
        aSel_o    = A_RS1;
        bSel_o    = B_RS2;
        wbSel_o   = WB_ALU;
        regWe_o   = 1'b0;
        memReq_o  = 1'b0;
        memWe_o   = 1'b0;
        branch_o  = 1'b0;
        jal_o     = 1'b0;
        illegal_o = 1'b0;
        case (opcode)
            OPC_OP: begin
                regWe_o = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: aluOp_o = ALU_ADD;
                    10'b0100000_000: aluOp_o = ALU_SUB;
                    10'b0000000_111: aluOp_o = ALU_AND;
                    10'b0000000_110: aluOp_o = ALU_OR;
                    10'b0000000_100: aluOp_o = ALU_XOR;
                    10'b0000000_010: aluOp_o = ALU_SLT;
                    10'b0000000_001: aluOp_o = ALU_SLL;
                    10'b0000000_101: aluOp_o = ALU_SRL;
                    default:         illegal_o = 1'b1;
                endcase
            end
            OPC_OPIMM: begin
                regWe_o = 1'b1;
                bSel_o  = B_IMM_I;
                case (funct3)
                    3'b000:  aluOp_o = ALU_ADD;
                    3'b111:  aluOp_o = ALU_AND;
                    3'b110:  aluOp_o = ALU_OR;
                    3'b100:  aluOp_o = ALU_XOR;
                    3'b010:  aluOp_o = ALU_SLT;
                    default: illegal_o = 1'b1; // Immediate shifts not supported
                endcase
            end
            OPC_LUI: begin
                regWe_o = 1'b1;
                aSel_o  = A_ZERO;
                bSel_o  = B_IMM_U;
            end
            OPC_LOAD: begin
                regWe_o   = 1'b1;
                memReq_o  = 1'b1;
                bSel_o    = B_IMM_I;
                wbSel_o   = WB_MEM;
                illegal_o = (funct3 != 3'b010); // LW only
            end
            OPC_STORE: begin
                memReq_o  = 1'b1;
                memWe_o   = 1'b1;
                bSel_o    = B_IMM_S;
                illegal_o = (funct3 != 3'b010); // SW only
            end
            OPC_BRANCH: begin
                branch_o = 1'b1;
                case (funct3)
                    3'b000:  aluOp_o = ALU_EQ;
                    3'b001:  aluOp_o = ALU_NE;
                    3'b100:  aluOp_o = ALU_LT;
                    default: illegal_o = 1'b1;
                endcase
            end
            OPC_JAL: begin
                jal_o   = 1'b1;
                regWe_o = 1'b1;
                wbSel_o = WB_PC4;
            end
            default: illegal_o = 1'b1; // Includes the all-zero word
        endcase
        if (illegal_o) begin
            regWe_o  = 1'b0;
            memReq_o = 1'b0;
            memWe_o  = 1'b0;
            branch_o = 1'b0;
            jal_o    = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/aluUnit.sv */
// ALU with arithmetic, logic, shift and branch compare operations
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  corePkg::aluOp_t op_i,
    input  corePkg::word_t  a_i,
    input  corePkg::word_t  b_i,
    output corePkg::word_t  result_o,
    output logic            flag_o
);
    import corePkg::*;

    always_comb begin
        result_o = '0;
        flag_o   = 1'b0;
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLL: result_o = a_i << b_i[4:0];
            ALU_SRL: result_o = a_i >> b_i[4:0];
            ALU_EQ:  flag_o = (a_i == b_i);
            ALU_NE:  flag_o = (a_i != b_i);
            ALU_LT:  flag_o = ($signed(a_i) < $signed(b_i)); // BLT is signed
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/registerFile.sv */
// General purpose register file with two read ports and one write port
`timescale 1ns/1ps
`default_nettype none

`include "coreParams.svh"

module registerFile (
    input  logic             clk_i,
    input  logic             we_i,
    input  corePkg::regIdx_t waddr_i,
    input  corePkg::regIdx_t raddr1_i,
    input  corePkg::regIdx_t raddr2_i,
    input  corePkg::word_t   wdata_i,
    output corePkg::word_t   rdata1_o,
    output corePkg::word_t   rdata2_o
);
    import corePkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i]; // x0 reads zero
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // A written register reads back and x0 stays zero
    assert property (@(posedge clk_i) we_i |=>
                     ((raddr1_i != $past(waddr_i))
                      || (rdata1_o == (($past(waddr_i) == '0) ? '0 : $past(wdata_i)))))
        else $error("Register read back differs from the last write");

endmodule

`default_nettype wire

/* design/processorCore.sv */
// Single-cycle RV32I subset core with load stall and halt on illegal instruction
`timescale 1ns/1ps
`default_nettype none

module processorCore (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           run_i,
    input  corePkg::word_t instr_i,
    output corePkg::word_t pc_o,
    output logic           halted_o,
    memBus.core            dBus
);
    import corePkg::*;

    word_t  pc;
    word_t  pcPlus4;
    word_t  nextPc;
    word_t  immI;
    word_t  immS;
    word_t  immB;
    word_t  immJ;
    word_t  immU;
    word_t  rs1Data;
    word_t  rs2Data;
    word_t  opA;
    word_t  opB;
    word_t  aluResult;
    word_t  wbData;
    aluOp_t aluOp;
    aSel_t  aSel;
    bSel_t  bSel;
    wbSel_t wbSel;
    logic   regWe;
    logic   memReq;
    logic   memWe;
    logic   branch;
    logic   jal;
    logic   illegal;
    logic   aluFlag;
    logic   active;
    logic   regWriteEn;
    logic   pcEn;

    instrDecoder i_dec (
        .instr_i   (instr_i),
        .aluOp_o   (aluOp),
        .aSel_o    (aSel),
        .bSel_o    (bSel),
        .wbSel_o   (wbSel),
        .regWe_o   (regWe),
        .memReq_o  (memReq),
        .memWe_o   (memWe),
        .branch_o  (branch),
        .jal_o     (jal),
        .illegal_o (illegal)
    );

    registerFile i_regs (
        .clk_i    (clk_i),
        .we_i     (regWriteEn),
        .waddr_i  (instr_i[11:7]),
        .raddr1_i (instr_i[19:15]),
        .raddr2_i (instr_i[24:20]),
        .wdata_i  (wbData),
        .rdata1_o (rs1Data),
        .rdata2_o (rs2Data)
    );

    aluUnit i_alu (
        .op_i     (aluOp),
        .a_i      (opA),
        .b_i      (opB),
        .result_o (aluResult),
        .flag_o   (aluFlag)
    );

    assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
    assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
    assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};
    assign immU = {instr_i[31:12], 12'b0};

    assign opA = (aSel == A_ZERO) ? '0 : rs1Data; // LUI adds to zero

    always_comb begin
        case (bSel)
            B_IMM_I: opB = immI;
            B_IMM_U: opB = immU;
            B_IMM_S: opB = immS;
            default: opB = rs2Data;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (wbSel)
            WB_MEM:  wbData = dBus.rdata;
            WB_PC4:  wbData = pcPlus4; // JAL link
            default: wbData = aluResult;
        endcase
    end

    always_comb begin
        if (branch && aluFlag) begin
            nextPc = pc + immB;
        end else if (jal) begin
            nextPc = pc + immJ;
        end else begin
            nextPc = pcPlus4;
        end
    end

    assign active     = run_i & ~halted_o;
    assign regWriteEn = regWe & active & ~dBus.stall;
    assign pcEn       = active & ~dBus.stall & ~illegal; // Hold PC on illegal

    assign dBus.req   = memReq & active;
    assign dBus.we    = memWe & active;
    assign dBus.addr  = aluResult;
    assign dBus.wdata = rs2Data;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc       <= '0;
            halted_o <= 1'b0;
        end else begin
            if (pcEn) begin
                pc <= nextPc;
            end
            if (active && illegal) begin
                halted_o <= 1'b1; // Sticky until reset
            end
        end
    end

    assign pc_o = pc;

    // Load data is written back only in the cycle after its stall
    assert property (@(posedge clk_i) disable iff (rst_i)
                     (regWriteEn && wbSel == WB_MEM) |-> (!dBus.stall && $past(dBus.stall)))
        else $error("Load write-back outside the cycle after its stall");

endmodule

`default_nettype wire

/* design/dataMemory.sv */
// Word-addressed data RAM with synchronous read and one-cycle load stall
`timescale 1ns/1ps
`default_nettype none

`include "coreParams.svh"

module dataMemory (
    input  logic clk_i,
    input  logic rst_i,
    memBus.mem   dBus
);
    import corePkg::*;

    word_t     ram [`DMEM_WORDS];
    dmemIdx_t  idx;
    memState_t state;
    logic      loadReq;

    assign idx     = dBus.addr[9:2];
    assign loadReq = dBus.req & ~dBus.we;

    assign dBus.stall = loadReq && (state == MEM_IDLE); // First load cycle

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state <= MEM_IDLE;
        end else begin
            case (state)
                MEM_IDLE: state <= loadReq ? MEM_WAIT : MEM_IDLE;
                default:  state <= MEM_IDLE; // Data valid this cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (dBus.req && dBus.we) begin
            ram[idx] <= dBus.wdata;
        end
        if (dBus.stall) begin
            dBus.rdata <= ram[idx];
        end
    end

    // A stalled load comes back once for its data at the same address
    assert property (@(posedge clk_i) disable iff (rst_i)
                     dBus.stall |=> (!dBus.stall
                                     && (!dBus.req || (!dBus.we && $stable(dBus.addr)))))
        else $error("Load stall not followed by its data cycle at the same address");

endmodule

`default_nettype wire

/* design/programMemory.sv */
// Program RAM with an external load port and asynchronous fetch
`timescale 1ns/1ps
`default_nettype none

`include "coreParams.svh"

module programMemory (
    input  logic              clk_i,
    input  logic              we_i,
    input  corePkg::pmemIdx_t waddr_i,
    input  corePkg::word_t    wdata_i,
    input  corePkg::word_t    pc_i,
    output corePkg::word_t    instr_o
);
    import corePkg::*;

    word_t ram [`PMEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            ram[waddr_i] <= wdata_i;
        end
    end

    assign instr_o = ram[pc_i[9:2]]; // Word index from the byte PC

endmodule

`default_nettype wire

/* design/processorSystem.sv */
// Processor system top level with core, program memory and data memory
`timescale 1ns/1ps
`default_nettype none

module processorSystem (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              run_i,
    input  logic              progWe_i,
    input  corePkg::pmemIdx_t progAddr_i,
    input  corePkg::word_t    progData_i,
    output corePkg::word_t    pc_o,
    output logic              storeStrobe_o,
    output corePkg::word_t    storeAddr_o,
    output corePkg::word_t    storeData_o,
    output logic              halted_o
);
    import corePkg::*;

    word_t instr;

    memBus dBus ();

    processorCore i_core (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .run_i    (run_i),
        .instr_i  (instr),
        .pc_o     (pc_o),
        .halted_o (halted_o),
        .dBus     (dBus.core)
    );

    dataMemory i_dmem (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .dBus  (dBus.mem)
    );

    programMemory i_pmem (
        .clk_i   (clk_i),
        .we_i    (progWe_i),
        .waddr_i (progAddr_i),
        .wdata_i (progData_i),
        .pc_i    (pc_o),
        .instr_o (instr)
    );

    assign storeStrobe_o = dBus.req & dBus.we;
    assign storeAddr_o   = dBus.addr;
    assign storeData_o   = dBus.wdata;

endmodule

`default_nettype wire

/* testbench/tbProcessorSystem.sv */
// Testbench for the processor system running a random program against an instruction-set model
`timescale 1ns/1ps
`default_nettype none

`include "coreParams.svh"

module tbProcessorSystem;
    import corePkg::*;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_SRL,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI, K_LUI, K_LW, K_SW,
        K_BEQ, K_BNE, K_BLT, K_JAL, K_HALT
    } instrKind_t;

    localparam int BODY_LEN    = 150;
    localparam int LOAD_WORDS  = 16; // Words that loads may read
    localparam int PROG_LEN    = (`REG_COUNT - 1) + LOAD_WORDS + BODY_LEN + `REG_COUNT + 1;
    localparam int CYCLE_LIMIT = 2 * PROG_LEN + `PMEM_WORDS + 100;

    logic     clk_i = 1'b0;
    logic     rst_i;
    logic     run_i;
    logic     progWe_i;
    pmemIdx_t progAddr_i;
    word_t    progData_i;
    word_t    pc_o;
    logic     storeStrobe_o;
    word_t    storeAddr_o;
    word_t    storeData_o;
    logic     halted_o;

    instrKind_t kind [PROG_LEN];
    regIdx_t    rdIdx [PROG_LEN];
    regIdx_t    rs1Idx [PROG_LEN];
    regIdx_t    rs2Idx [PROG_LEN];
    word_t      immVal [PROG_LEN];
    word_t      prog [PROG_LEN];
    word_t      expAddr [$];
    word_t      expData [$];
    word_t      haltPc;
    int         fill;
    int         seenStores  = 0;
    int         valueErrors = 0;
    int         otherErrors = 0;
    int         cycles      = 0;

    processorSystem i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .run_i         (run_i),
        .progWe_i      (progWe_i),
        .progAddr_i    (progAddr_i),
        .progData_i    (progData_i),
        .pc_o          (pc_o),
        .storeStrobe_o (storeStrobe_o),
        .storeAddr_o   (storeAddr_o),
        .storeData_o   (storeData_o),
        .halted_o      (halted_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic finishRun();
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    function automatic word_t randImm12();
        logic [11:0] v;
        v = 12'($urandom());
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t encodeInstr(input instrKind_t k, input regIdx_t d,
                                          input regIdx_t s1, input regIdx_t s2, input word_t im);
        case (k)
            K_ADD:  return {7'h00, s2, s1, 3'b000, d, 7'h33};
            K_SUB:  return {7'h20, s2, s1, 3'b000, d, 7'h33};
            K_AND:  return {7'h00, s2, s1, 3'b111, d, 7'h33};
            K_OR:   return {7'h00, s2, s1, 3'b110, d, 7'h33};
            K_XOR:  return {7'h00, s2, s1, 3'b100, d, 7'h33};
            K_SLT:  return {7'h00, s2, s1, 3'b010, d, 7'h33};
            K_SLL:  return {7'h00, s2, s1, 3'b001, d, 7'h33};
            K_SRL:  return {7'h00, s2, s1, 3'b101, d, 7'h33};
            K_ADDI: return {im[11:0], s1, 3'b000, d, 7'h13};
            K_ANDI: return {im[11:0], s1, 3'b111, d, 7'h13};
            K_ORI:  return {im[11:0], s1, 3'b110, d, 7'h13};
            K_XORI: return {im[11:0], s1, 3'b100, d, 7'h13};
            K_SLTI: return {im[11:0], s1, 3'b010, d, 7'h13};
            K_LUI:  return {im[31:12], d, 7'h37};
            K_LW:   return {im[11:0], s1, 3'b010, d, 7'h03};
            K_SW:   return {im[11:5], s2, s1, 3'b010, im[4:0], 7'h23};
            K_BEQ:  return {im[12], im[10:5], s2, s1, 3'b000, im[4:1], im[11], 7'h63};
            K_BNE:  return {im[12], im[10:5], s2, s1, 3'b001, im[4:1], im[11], 7'h63};
            K_BLT:  return {im[12], im[10:5], s2, s1, 3'b100, im[4:1], im[11], 7'h63};
            K_JAL:  return {im[20], im[10:1], im[11], im[19:12], d, 7'h6f};
            default: return '0; // Zero word stops the core
        endcase
    endfunction

    task automatic addInstr(input instrKind_t k, input regIdx_t d, input regIdx_t s1,
                            input regIdx_t s2, input word_t im);
        kind[fill]   = k;
        rdIdx[fill]  = d;
        rs1Idx[fill] = s1;
        rs2Idx[fill] = s2;
        immVal[fill] = im;
        prog[fill]   = encodeInstr(k, d, s1, s2, im);
        fill++;
    endtask

    task automatic buildProgram();
        instrKind_t k;
        regIdx_t    d;
        regIdx_t    s1;
        regIdx_t    s2;
        word_t      im;
        fill = 0;
        for (int r = 1; r < `REG_COUNT; r++) begin
            addInstr(K_LUI, regIdx_t'(r), '0, '0, $urandom() & 32'hffff_f000);
        end
        for (int w = 0; w < LOAD_WORDS; w++) begin
            addInstr(K_SW, '0, '0, regIdx_t'(w + 1), word_t'(4 * w));
        end
        for (int i = 0; i < BODY_LEN; i++) begin
            d  = regIdx_t'($urandom_range(31));
            s1 = regIdx_t'($urandom_range(31));
            s2 = regIdx_t'($urandom_range(31));
            im = randImm12();
            if (i % 10 == 9) begin
                k = K_SW;
            end else begin
                k = instrKind_t'($urandom_range(int'(K_JAL)));
            end
            case (k)
                K_LUI: im = $urandom() & 32'hffff_f000;
                K_LW: begin
                    s1 = '0;
                    im = word_t'(4 * $urandom_range(LOAD_WORDS - 1));
                end
                K_SW: begin
                    s1 = '0;
                    im = word_t'(4 * $urandom_range(63));
                end
                K_BEQ, K_BNE, K_BLT, K_JAL: im = word_t'(4 * $urandom_range(2, 4)); // Forward only
                default: ;
            endcase
            addInstr(k, d, s1, s2, im);
        end
        for (int r = 0; r < `REG_COUNT; r++) begin
            addInstr(K_SW, '0, '0, regIdx_t'(r), word_t'(256 + 4 * r)); // Register dump
        end
        addInstr(K_HALT, '0, '0, '0, '0);
    endtask

    task automatic runModel();
        word_t regs [`REG_COUNT];
        word_t mem [`DMEM_WORDS];
        word_t a;
        word_t b;
        word_t addr;
        word_t res;
        int    pc;
        int    next;
        logic  wr;
        logic  taken;
        foreach (regs[r]) begin
            regs[r] = '0;
        end
        pc = 0;
        while (pc < PROG_LEN && kind[pc] != K_HALT) begin
            a     = regs[rs1Idx[pc]];
            b     = regs[rs2Idx[pc]];
            addr  = a + immVal[pc];
            res   = '0;
            wr    = 1'b1;
            next  = pc + 1;
            taken = (kind[pc] == K_BEQ && a == b) || (kind[pc] == K_BNE && a != b)
                    || (kind[pc] == K_BLT && $signed(a) < $signed(b));
            case (kind[pc])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = word_t'($signed(a) < $signed(b));
                K_SLL:  res = a << b[4:0];
                K_SRL:  res = a >> b[4:0];
                K_ADDI: res = addr;
                K_ANDI: res = a & immVal[pc];
                K_ORI:  res = a | immVal[pc];
                K_XORI: res = a ^ immVal[pc];
                K_SLTI: res = word_t'($signed(a) < $signed(immVal[pc]));
                K_LUI:  res = immVal[pc];
                K_LW:   res = mem[addr[9:2]];
                K_SW: begin
                    wr = 1'b0;
                    mem[addr[9:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                K_BEQ, K_BNE, K_BLT: begin
                    wr = 1'b0;
                    if (taken) begin
                        next = pc + int'(immVal[pc]) / 4;
                    end
                end
                K_JAL: begin
                    res  = word_t'(4 * (pc + 1)); // Link is the return address
                    next = pc + int'(immVal[pc]) / 4;
                end
                default: wr = 1'b0;
            endcase
            if (wr && rdIdx[pc] != '0) begin
                regs[rdIdx[pc]] = res;
            end
            pc = next;
        end
        haltPc = word_t'(4 * pc);
    endtask

    // Store events compared in program order
    always @(negedge clk_i) begin
        if (!rst_i && storeStrobe_o) begin
            if (seenStores < expAddr.size()) begin
                checkWord("storeAddr_o", storeAddr_o, expAddr[seenStores]);
                checkWord("storeData_o", storeData_o, expData[seenStores]);
            end else begin
                $display("Store seen after the model's last store, at pc 0x%08h", pc_o);
                otherErrors++;
            end
            seenStores++;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the core never halted", cycles);
            otherErrors++;
            finishRun();
        end
    end

    initial begin
        rst_i      = 1'b1;
        run_i      = 1'b0;
        progWe_i   = 1'b0;
        progAddr_i = '0;
        progData_i = '0;
        void'($urandom(32'h578d_5dc9));
        buildProgram();
        runModel();
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        checkWord("pc_o", pc_o, '0);
        checkBit("storeStrobe_o", storeStrobe_o, 1'b0);
        checkBit("halted_o", halted_o, 1'b0);
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk_i);
            progWe_i   <= 1'b1;
            progAddr_i <= pmemIdx_t'(i);
            progData_i <= prog[i];
        end
        @(posedge clk_i);
        progWe_i <= 1'b0;
        @(negedge clk_i);
        checkWord("pc_o", pc_o, '0); // Still parked while run_i is low
        checkBit("halted_o", halted_o, 1'b0);
        @(posedge clk_i);
        run_i <= 1'b1;
        while (!halted_o) @(negedge clk_i);
        repeat (5) begin
            checkWord("pc_o", pc_o, haltPc);
            checkBit("halted_o", halted_o, 1'b1);
            @(negedge clk_i);
        end
        checkWord("store count", word_t'(seenStores), word_t'(expAddr.size()));
        finishRun();
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/corePkg.sv
design/memBus.sv
design/instrDecoder.sv
design/aluUnit.sv
design/registerFile.sv
design/processorCore.sv
design/dataMemory.sv
design/programMemory.sv
design/processorSystem.sv
testbench/tbProcessorSystem.sv

/* run.sh */
#!/usr/bin/env bash
# Build the processor system testbench with Verilator, run it and check the log
cd "$(dirname "$0")" \
    && rm -rf obj_dir sim.log \
    && verilator --binary --timing --assert -f files.f --top-module tbProcessorSystem -o simv \
    && ./obj_dir/simv | tee sim.log \
    && grep -qx "PASS: all tests" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
